//--- bus_scheduler.sv
/*
  five-phase clock enable and SDRAM command slot arbiter
  the SDRAM controller must return read data within four cycles
  loader writes win in any phase, NES requests only go out in ph_cmd
  no back-pressure, the memory outputs are combinational
*/
`timescale 1ns/1ps
`default_nettype none
`include "nes_board_params.svh"

module bus_scheduler (
  input  wire                        clk,
  input  wire                        sys_resetn,
  input  wire                        loader_done,
  input  wire                        nes_read_cpu,
  input  wire                        nes_read_ppu,
  input  wire                        nes_write,
  input  wire nes_board_pkg::mem_addr_t nes_addr,
  input  wire nes_board_pkg::byte_t  nes_dout,
  input  wire                        loader_write,
  input  wire                        loader_refresh,
  input  wire nes_board_pkg::mem_addr_t loader_addr,
  input  wire nes_board_pkg::byte_t  loader_data,
  output logic                       run_nes,
  output logic                       mem_read_a,
  output logic                       mem_read_b,
  output logic                       mem_write,
  output logic                       mem_refresh,
  output nes_board_pkg::mem_addr_t   mem_addr,
  output nes_board_pkg::byte_t       mem_din
);

  nes_board_pkg::ce_phase_e phase_q;

  logic run_mem;
  logic nes_req;
  logic last_phase;

  // phase   cmd | active | rd/wr | wait | run
  // the NES tick sees data issued four cycles earlier
  assign last_phase = (phase_q == nes_board_pkg::ce_phase_e'(`nb_ce_phases - 1));

  always_ff @(posedge clk) begin
    if (!sys_resetn)
      phase_q <= nes_board_pkg::ph_cmd;
    else if (last_phase)
      phase_q <= nes_board_pkg::ph_cmd;
    else
      phase_q <= nes_board_pkg::ce_phase_e'(phase_q + 3'd1);
  end

  // NES stays in reset until the game is loaded
  assign run_mem = loader_done && (phase_q == nes_board_pkg::ph_cmd);
  assign run_nes = loader_done && (phase_q == nes_board_pkg::ph_run);

  assign nes_req = nes_read_cpu || nes_read_ppu || nes_write;

  // command slot
  assign mem_read_a = !loader_write && run_mem && nes_read_cpu;
  assign mem_read_b = !loader_write && run_mem && nes_read_ppu;
  assign mem_write  = loader_write || (run_mem && nes_write);

  // idle slot and loader gaps go to refresh
  assign mem_refresh = !loader_write && ((run_mem && !nes_req) || loader_refresh);

  assign mem_addr = loader_write ? loader_addr : nes_addr;
  assign mem_din  = loader_write ? loader_data : nes_dout;

endmodule

`default_nettype wire

//--- host_regs.sv
/*
  host register decoder for the UART byte bus
  writes are single-cycle pulses and registers update on the following cycle
  writes to unmapped addresses are ignored
*/
`timescale 1ns/1ps
`default_nettype none
`include "nes_board_params.svh"

module host_regs (
  input  wire                       clk,
  input  wire                       sys_resetn,
  input  wire                       host_write,
  input  wire nes_board_pkg::host_addr_t host_addr,
  input  wire nes_board_pkg::byte_t host_data,
  output nes_board_pkg::byte_t      loader_byte,
  output logic                      loader_strobe,
  output logic                      loader_reset,
  output nes_board_pkg::nes_buttons_t host_btn1,
  output nes_board_pkg::nes_buttons_t host_btn2
);

  logic conf_q;   // bit 0 of the loader config register

  logic wr_conf;
  logic wr_loader;
  logic wr_btn1;
  logic wr_btn2;

  assign wr_conf   = host_write && (host_addr == `nb_host_addr_conf);
  assign wr_loader = host_write && (host_addr == `nb_host_addr_loader);
  assign wr_btn1   = host_write && (host_addr == `nb_host_addr_btn1);
  assign wr_btn2   = host_write && (host_addr == `nb_host_addr_btn2);

  // control registers
  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      conf_q        <= 1'b0;
      host_btn1     <= '0;
      host_btn2     <= '0;
      loader_strobe <= 1'b0;
    end else begin
      loader_strobe <= wr_loader;   // one-cycle pulse
      if (wr_conf)
        conf_q <= host_data[0];
      if (wr_btn1)
        host_btn1 <= host_data;
      if (wr_btn2)
        host_btn2 <= host_data;
    end
  end

  // data byte travels with the strobe
  always_ff @(posedge clk) begin
    if (wr_loader)
      loader_byte <= host_data;
  end

  // loader held in reset by system reset or by the host
  assign loader_reset = !sys_resetn || conf_q;

endmodule

`default_nettype wire

//--- joypad_shifter.sv
/*
  one NES controller port as seen by the core
  strobe high reloads the buttons every cycle and wins over a shift
  a falling edge of joypad_clock shifts right one cycle later, zero filled
*/
`timescale 1ns/1ps
`default_nettype none

module joypad_shifter (
  input  wire                       clk,
  input  wire                       sys_resetn,
  input  wire                       joypad_strobe,
  input  wire                       joypad_clock,
  input  wire nes_board_pkg::nes_buttons_t host_btn,
  input  wire nes_board_pkg::nes_buttons_t pad_btn,
  output logic                      joypad_data
);

  nes_board_pkg::nes_buttons_t shift_q;
  logic clock_q;
  logic clock_fall;

  assign clock_fall = clock_q && !joypad_clock;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      shift_q <= '0;
      clock_q <= 1'b0;
    end else begin
      clock_q <= joypad_clock;
      if (joypad_strobe)
        shift_q <= host_btn | pad_btn;      // override ORed with the pad
      else if (clock_fall)
        shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  // A comes out first
  assign joypad_data = shift_q[0];

endmodule

`default_nettype wire

//--- nes_board_ctrl.f
nes_board_pkg.sv
host_regs.sv
pad_mapper.sv
joypad_shifter.sv
bus_scheduler.sv
nes_board_ctrl.sv
tb_nes_board_ctrl.sv
+incdir+.

//--- nes_board_ctrl.sv
/*
  board glue between the NES core, game loader, SDRAM controller and host UART
  all outside blocks connect through loose ports on this level
  SDRAM read data goes from the memory controller to the core directly
*/
`timescale 1ns/1ps
`default_nettype none

module nes_board_ctrl (
  input  wire                        clk,
  input  wire                        sys_resetn,

  // host byte bus from the UART receiver
  input  wire                        host_write,
  input  wire nes_board_pkg::host_addr_t host_addr,
  input  wire nes_board_pkg::byte_t  host_data,

  // game loader
  output nes_board_pkg::byte_t       loader_byte,
  output logic                       loader_strobe,
  output logic                       loader_reset,
  input  wire                        loader_done,
  input  wire                        loader_write,
  input  wire                        loader_refresh,
  input  wire nes_board_pkg::mem_addr_t loader_addr,
  input  wire nes_board_pkg::byte_t  loader_data,

  // DualShock links
  input  wire nes_board_pkg::ds_byte_t ds1_byte0,
  input  wire nes_board_pkg::ds_byte_t ds1_byte1,
  input  wire nes_board_pkg::ds_byte_t ds2_byte0,
  input  wire nes_board_pkg::ds_byte_t ds2_byte1,

  // NES core
  input  wire                        joypad_strobe,
  input  wire [1:0]                  joypad_clock,
  output logic [1:0]                 joypad_data,
  input  wire                        nes_read_cpu,
  input  wire                        nes_read_ppu,
  input  wire                        nes_write,
  input  wire nes_board_pkg::mem_addr_t nes_addr,
  input  wire nes_board_pkg::byte_t  nes_dout,
  output logic                       run_nes,

  // SDRAM controller command
  output logic                       mem_read_a,
  output logic                       mem_read_b,
  output logic                       mem_write,
  output logic                       mem_refresh,
  output nes_board_pkg::mem_addr_t   mem_addr,
  output nes_board_pkg::byte_t       mem_din,

  input  wire                        uart_rxd,
  output logic [1:0]                 led
);

  nes_board_pkg::nes_buttons_t host_btn1;
  nes_board_pkg::nes_buttons_t host_btn2;
  nes_board_pkg::nes_buttons_t pad_btn1;
  nes_board_pkg::nes_buttons_t pad_btn2;

  host_regs host_regs_i (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .host_write    (host_write),
    .host_addr     (host_addr),
    .host_data     (host_data),
    .loader_byte   (loader_byte),
    .loader_strobe (loader_strobe),
    .loader_reset  (loader_reset),
    .host_btn1     (host_btn1),
    .host_btn2     (host_btn2)
  );

  pad_mapper pad_mapper1_i (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .ds_byte0   (ds1_byte0),
    .ds_byte1   (ds1_byte1),
    .pad_btn    (pad_btn1)
  );

  pad_mapper pad_mapper2_i (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .ds_byte0   (ds2_byte0),
    .ds_byte1   (ds2_byte1),
    .pad_btn    (pad_btn2)
  );

  // one shifter per controller port
  joypad_shifter joypad1_i (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .joypad_strobe (joypad_strobe),
    .joypad_clock  (joypad_clock[0]),
    .host_btn      (host_btn1),
    .pad_btn       (pad_btn1),
    .joypad_data   (joypad_data[0])
  );

  joypad_shifter joypad2_i (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .joypad_strobe (joypad_strobe),
    .joypad_clock  (joypad_clock[1]),
    .host_btn      (host_btn2),
    .pad_btn       (pad_btn2),
    .joypad_data   (joypad_data[1])
  );

  bus_scheduler bus_scheduler_i (
    .clk            (clk),
    .sys_resetn     (sys_resetn),
    .loader_done    (loader_done),
    .nes_read_cpu   (nes_read_cpu),
    .nes_read_ppu   (nes_read_ppu),
    .nes_write      (nes_write),
    .nes_addr       (nes_addr),
    .nes_dout       (nes_dout),
    .loader_write   (loader_write),
    .loader_refresh (loader_refresh),
    .loader_addr    (loader_addr),
    .loader_data    (loader_data),
    .run_nes        (run_nes),
    .mem_read_a     (mem_read_a),
    .mem_read_b     (mem_read_b),
    .mem_write      (mem_write),
    .mem_refresh    (mem_refresh),
    .mem_addr       (mem_addr),
    .mem_din        (mem_din)
  );

  // led 0 lit while loading, led 1 shows UART activity
  assign led = {uart_rxd, ~loader_done};

endmodule

`default_nettype wire

//--- nes_board_params.svh
/*
  constants shared by the board glue around the NES core
  host addresses assume the 8-bit register map of the UART host bus
  the autofire half period is in clk cycles and must be at least 1
*/
`ifndef NES_BOARD_PARAMS_SVH
`define NES_BOARD_PARAMS_SVH

// host register map
`define nb_host_addr_conf   8'h35   // loader config, bit 0 holds the loader in reset
`define nb_host_addr_loader 8'h37   // loader data byte stream
`define nb_host_addr_btn1   8'h40   // button override, port 1
`define nb_host_addr_btn2   8'h41   // button override, port 2

// clock enable schedule
// one SDRAM command slot and one NES tick per round
`define nb_ce_phases 5

// autofire
`define nb_autofire_half 16         // cycles per half period

`endif

//--- nes_board_pkg.sv
/*
  shared types for the NES board glue
  button vectors are active high in NES order, DualShock bytes are active low
  the address type covers a 4 MB SDRAM space
*/
`default_nettype none

package nes_board_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [7:0] host_addr_t;

  // R L D U START SELECT B A, bit 0 is A
  typedef logic [7:0] nes_buttons_t;

  // raw button byte from the DualShock link, 0 means pressed
  typedef logic [7:0] ds_byte_t;

  typedef logic [21:0] mem_addr_t;  // 4 MB

  // one phase per clk cycle
  typedef enum logic [2:0] {
    ph_cmd,     // SDRAM command slot
    ph_active,
    ph_rdwr,
    ph_wait,
    ph_run      // NES core ticks here
  } ce_phase_e;

endpackage

`default_nettype wire

//--- pad_mapper.sv
/*
  maps one DualShock's two button bytes to NES buttons
  square gives autofire B, triangle gives autofire A
  the output is registered, so it lags the link bytes by one cycle
*/
`timescale 1ns/1ps
`default_nettype none
`include "nes_board_params.svh"

module pad_mapper #(
  parameter int autofire_half = `nb_autofire_half
) (
  input  wire                       clk,
  input  wire                       sys_resetn,
  input  wire nes_board_pkg::ds_byte_t ds_byte0,
  input  wire nes_board_pkg::ds_byte_t ds_byte1,
  output nes_board_pkg::nes_buttons_t pad_btn
);

  localparam int cnt_w = (autofire_half > 1) ? $clog2(autofire_half) : 1;

  // index 1 is square (B), index 0 is triangle (A)
  logic [1:0] af_held;
  logic [1:0] af_out;
  logic [1:0] af_tog;
  logic [cnt_w-1:0] af_cnt [2];

  nes_board_pkg::nes_buttons_t btn_next;

  assign af_held = {~ds_byte1[7], ~ds_byte1[4]};

  for (genvar i = 0; i < 2; i++) begin : g_af
    always_ff @(posedge clk) begin
      if (!sys_resetn) begin
        af_cnt[i] <= '0;
        af_tog[i] <= 1'b1;
      end else if (!af_held[i]) begin
        af_cnt[i] <= '0;      // restart for the next press
        af_tog[i] <= 1'b1;    // first held cycle fires
      end else if (af_cnt[i] == cnt_w'(autofire_half - 1)) begin
        af_cnt[i] <= '0;
        af_tog[i] <= ~af_tog[i];
      end else begin
        af_cnt[i] <= af_cnt[i] + 1'b1;
      end
    end

    assign af_out[i] = af_held[i] && af_tog[i];
  end

  // DualShock byte 0 is L D R U St R3 L3 Se from bit 7 down
  assign btn_next = {
    ~ds_byte0[5],                 // R
    ~ds_byte0[7],                 // L
    ~ds_byte0[6],                 // D
    ~ds_byte0[4],                 // U
    ~ds_byte0[3],                 // START
    ~ds_byte0[0],                 // SELECT
    ~ds_byte1[6] | af_out[1],     // B from X or square autofire
    ~ds_byte1[5] | af_out[0]      // A from circle or triangle autofire
  };

  always_ff @(posedge clk) begin
    if (!sys_resetn)
      pad_btn <= '0;
    else
      pad_btn <= btn_next;
  end

endmodule

`default_nettype wire

//--- tb_nes_board_ctrl.sv
/*
  random-stimulus testbench for the NES board glue, with a cycle model
  inputs change on the falling clk edge where registered outputs are also checked
  stops at the first mismatch
*/
`timescale 1ns/1ps
`default_nettype none
`include "nes_board_params.svh"

module tb_nes_board_ctrl;

  logic clk;
  logic sys_resetn;
  logic host_write;
  logic [7:0] host_addr, host_data, loader_byte, loader_data, nes_dout, mem_din;
  logic loader_strobe, loader_reset, loader_done, loader_write, loader_refresh;
  logic [21:0] loader_addr, nes_addr, mem_addr;
  logic [7:0] ds1_byte0, ds1_byte1, ds2_byte0, ds2_byte1;
  logic joypad_strobe;
  logic [1:0] joypad_clock, joypad_data, led;
  logic nes_read_cpu, nes_read_ppu, nes_write, run_nes, uart_rxd;
  logic mem_read_a, mem_read_b, mem_write, mem_refresh;

  // model state
  logic [7:0] m_conf, m_byte;
  logic m_strobe;
  logic [7:0] m_btn [2];
  logic [7:0] m_pad [2];
  logic [7:0] m_shift [2];
  logic m_jclk_q [2];
  int m_held [2][2];    // consecutive held cycles per [port][0=triangle 1=square]
  int m_phase;
  bit m_valid;

  nes_board_ctrl nes_board_ctrl_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL %s expected %0h actual %0h", name, exp, act);
      $display("Verification failed");
      $fatal(1, "mismatch");
    end
  endtask

  function automatic logic autofire(input int n);
    return ((n / `nb_autofire_half) % 2) == 0;   // on at first and then toggling
  endfunction

  function automatic logic [7:0] map_pad(input logic [7:0] b0, input logic [7:0] b1,
                                         input logic af_b, input logic af_a);
    return {~b0[5], ~b0[7], ~b0[6], ~b0[4], ~b0[3], ~b0[0], ~b1[6] | af_b, ~b1[5] | af_a};
  endfunction

  task automatic update_model();
    logic [7:0] b0, b1;
    logic af_a, af_b;
    if (!sys_resetn) begin
      m_conf = 0;
      m_btn[0] = 0;
      m_btn[1] = 0;
      m_strobe = 0;
      m_phase = 0;
      for (int k = 0; k < 2; k++) begin
        m_pad[k] = 0;
        m_shift[k] = 0;
        m_jclk_q[k] = 0;
        m_held[k][0] = 0;
        m_held[k][1] = 0;
      end
    end else begin
      for (int k = 0; k < 2; k++) begin
        b0 = (k == 0) ? ds1_byte0 : ds2_byte0;
        b1 = (k == 0) ? ds1_byte1 : ds2_byte1;
        af_a = !b1[4] && autofire(m_held[k][0]);
        af_b = !b1[7] && autofire(m_held[k][1]);
        if (joypad_strobe)
          m_shift[k] = m_btn[k] | m_pad[k];
        else if (m_jclk_q[k] && !joypad_clock[k])
          m_shift[k] = m_shift[k] >> 1;
        m_jclk_q[k] = joypad_clock[k];
        m_pad[k] = map_pad(b0, b1, af_b, af_a);
        m_held[k][0] = b1[4] ? 0 : m_held[k][0] + 1;
        m_held[k][1] = b1[7] ? 0 : m_held[k][1] + 1;
      end
      m_strobe = host_write && (host_addr == `nb_host_addr_loader);
      if (m_strobe)
        m_byte = host_data;
      if (host_write && host_addr == `nb_host_addr_conf) m_conf = host_data;
      if (host_write && host_addr == `nb_host_addr_btn1) m_btn[0] = host_data;
      if (host_write && host_addr == `nb_host_addr_btn2) m_btn[1] = host_data;
      m_phase = (m_phase == `nb_ce_phases - 1) ? 0 : m_phase + 1;
    end
    m_valid = 1;
  endtask

  task automatic check_comb();
    logic run_mem;
    check("led", {uart_rxd, ~loader_done}, led);
    if (!sys_resetn)
      check("loader_reset_rst", 1, loader_reset);
    if (!m_valid)
      return;
    check("loader_reset", !sys_resetn || m_conf[0], loader_reset);
    run_mem = loader_done && m_phase == 0;
    check("run_nes", loader_done && m_phase == `nb_ce_phases - 1, run_nes);
    if (loader_write) begin
      check("mem_write_ld", 1, mem_write);
      check("mem_addr_ld", loader_addr, mem_addr);
      check("mem_din_ld", loader_data, mem_din);
    end else if (run_mem) begin
      check("mem_write_nes", nes_write, mem_write);
      if (nes_read_cpu || nes_read_ppu || nes_write) begin
        check("mem_addr_nes", nes_addr, mem_addr);
        check("mem_din_nes", nes_dout, mem_din);
      end
    end else begin
      check("mem_write_idle", 0, mem_write);
    end
    check("mem_read_a", !loader_write && run_mem && nes_read_cpu, mem_read_a);
    check("mem_read_b", !loader_write && run_mem && nes_read_ppu, mem_read_b);
    check("mem_refresh", !loader_write &&
          ((run_mem && !(nes_read_cpu || nes_read_ppu || nes_write)) || loader_refresh),
          mem_refresh);
  endtask

  task automatic cycle();
    #1 check_comb();
    @(posedge clk);
    update_model();
    @(negedge clk);
    check("loader_strobe", m_strobe, loader_strobe);
    if (m_strobe)
      check("loader_byte", m_byte, loader_byte);
    check("joypad_data", {m_shift[1][0], m_shift[0][0]}, joypad_data);
  endtask

  // waits for an idle command slot shown as a refresh
  task automatic wait_refresh_slot();
    int n;
    n = 0;
    #1;
    while (!mem_refresh) begin
      if (n == 20) begin
        $display("Verification failed");
        $fatal(1, "no refresh slot seen within 20 cycles");
      end
      cycle();
      n++;
      #1;
    end
  endtask

  initial begin
    int unsigned seed;
    logic [7:0] word [2];
    seed = $urandom(32'he482);
    {sys_resetn, host_write, host_addr, host_data} = '0;
    {loader_done, loader_write, loader_refresh, loader_addr, loader_data} = '0;
    {ds1_byte0, ds1_byte1, ds2_byte0, ds2_byte1} = '1;
    {joypad_strobe, joypad_clock, nes_read_cpu, nes_read_ppu, nes_write} = '0;
    {nes_addr, nes_dout, uart_rxd} = '0;
    m_valid = 0;
    @(negedge clk);
    repeat (16) cycle();
    sys_resetn = 1'b1;

    // host writes including unused addresses
    for (int i = 0; i < 400; i++) begin
      host_write = $urandom_range(0, 1);
      case ($urandom_range(0, 4))
        0: host_addr = `nb_host_addr_conf;
        1: host_addr = `nb_host_addr_loader;
        2: host_addr = `nb_host_addr_btn1;
        3: host_addr = `nb_host_addr_btn2;
        default: host_addr = $urandom;
      endcase
      host_data = $urandom;
      cycle();
    end
    host_write = 0;

    // joypad readout with autofire released
    for (int t = 0; t < 20; t++) begin
      host_write = 1;
      host_addr = `nb_host_addr_btn1;
      host_data = $urandom & $urandom;   // sparse override so pad bits still show
      ds1_byte0 = $urandom;
      ds1_byte1 = $urandom | 8'h90;
      ds2_byte0 = $urandom;
      ds2_byte1 = $urandom | 8'h90;
      cycle();
      host_addr = `nb_host_addr_btn2;
      host_data = $urandom & $urandom;
      cycle();
      host_write = 0;
      joypad_strobe = 1;
      repeat (2) cycle();
      joypad_strobe = 0;
      for (int k = 0; k < 2; k++)
        word[k] = m_btn[k] | m_pad[k];
      for (int i = 0; i < 10; i++) begin
        check("joypad_read0", (i < 8) ? word[0][i] : 1'b0, joypad_data[0]);
        check("joypad_read1", (i < 8) ? word[1][i] : 1'b0, joypad_data[1]);
        joypad_clock = 2'b11;
        repeat (2) cycle();
        joypad_clock = 2'b00;
        repeat (2) cycle();
      end
    end

    // autofire held for random lengths and read through random strobe and clocks
    for (int t = 0; t < 40; t++) begin
      ds1_byte1 = $urandom;
      ds2_byte1 = $urandom;
      repeat ($urandom_range(1, 70)) begin
        joypad_strobe = $urandom_range(0, 1);
        joypad_clock = $urandom;
        cycle();
      end
    end

    // run_nes lands four cycles after an idle slot
    loader_done = 1;
    wait_refresh_slot();
    repeat (4) cycle();
    check("run_nes_slot", 1, run_nes);

    // random bus traffic plus loader_done and led inputs
    for (int i = 0; i < 600; i++) begin
      if ($urandom_range(0, 31) == 0) loader_done = ~loader_done;
      {loader_write, loader_refresh} = $urandom;
      {nes_read_cpu, nes_read_ppu, nes_write} = $urandom;
      loader_addr = $urandom;
      loader_data = $urandom;
      nes_addr = $urandom;
      nes_dout = $urandom;
      uart_rxd = $urandom;
      cycle();
    end

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire
